//--- compile.f
common/core_pkg.sv
common/rf_if.sv
design/reg_file.sv
design/instr_decode.sv
design/alu.sv
design/core_seq.sv
design/core_top.sv
tests/core_checker.sv
tests/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@result="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_core.sv
// ==========================================================================
// tb_core
// Testbench for the RV32I-subset core: clock, reset, a req/ack memory
// model with random latency, a program table and the test loop.
// ==========================================================================
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam int num_tests      = 13;
    localparam int body_words     = 6;
    localparam int words_per_test = body_words + 2;
    localparam int mem_words      = 256;
    localparam int timeout_cycles = 40 * words_per_test * num_tests + 100;

    logic  clk         = 1'b0;
    logic  rst         = 1'b0;
    word_t mem_rd_data = '0;
    logic  mem_ack     = 1'b0;
    word_t mem_addr;
    word_t mem_wr_data;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t out;
    logic  out_valid;
    logic  halt;

    logic             test_done = 1'b0;
    logic [95:0]      test_name = '0;
    logic [2:0][31:0] exp_vals  = '0;
    int               exp_n     = 0;
    logic             exp_halt  = 1'b0;
    int               pass_count;
    int               fail_count;

    // program table with one row per test
    logic [95:0]      names     [num_tests];
    word_t            prog      [num_tests][body_words];
    logic [2:0][31:0] exp_tab   [num_tests];
    int               exp_count [num_tests];
    logic             halt_tab  [num_tests];
    int               rows = 0;
    int               cols = 0;

    int    cur_test = 0;
    word_t mem [mem_words];
    int    wait_cnt = 0;
    logic  waiting  = 1'b0;
    int    cycles   = 0;

    core_top core_top_i (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out         (out),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    core_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .out        (out),
        .out_valid  (out_valid),
        .halt       (halt),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_ack    (mem_ack),
        .mem_addr   (mem_addr),
        .test_done  (test_done),
        .test_name  (test_name),
        .exp_vals   (exp_vals),
        .exp_n      (exp_n),
        .exp_halt   (exp_halt),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #5 clk = ~clk;

    // instruction encoders following the RV32I formats
    function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic word_t s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
    endfunction

    function automatic word_t u_type(int imm20, int rd);
        return {imm20[19:0], rd[4:0], LUI};
    endfunction

    // memory image with an x31 = out_addr prologue at 128 and the test body from 136
    function automatic word_t image_word(int t, int idx);
        int slot;
        slot = idx - 34;
        if (idx == 32) begin
            return u_type(32'hf4, 31);
        end
        if (idx == 33) begin
            return i_type(32'h240, 31, 0, 31, OP_IMM);
        end
        if (slot >= 0 && slot < body_words) begin
            return prog[t][slot];
        end
        // the zero word after the body is an invalid opcode and halts the core
        if (slot == body_words) begin
            return '0;
        end
        return 32'h5a5a_0000 | word_t'(idx);
    endfunction

    task automatic add_test(logic [95:0] name, int n, word_t e0, word_t e1, word_t e2);
        names[rows]     = name;
        exp_tab[rows]   = {e2, e1, e0};
        exp_count[rows] = n;
        halt_tab[rows]  = 1'b1;
        rows            = rows + 1;
        cols            = 0;
    endtask

    task automatic add_word(word_t w);
        prog[rows-1][cols] = w;
        cols               = cols + 1;
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            for (int i = 0; i < body_words; i++) begin
                prog[t][i] = '0;
            end
        end
        add_test("imm_xor_srl ", 2, 32'hffffff0b, 32'h0fffffff, 0);
        add_word(i_type(-5, 0, 0, 1, OP_IMM));
        add_word(i_type(32'h0f0, 1, 4, 2, OP_IMM));
        add_word(s_type(0, 2, 31));
        add_word(i_type(4, 1, 5, 3, OP_IMM));
        add_word(s_type(0, 3, 31));
        add_word(s_type(4, 0, 31));
        add_test("imm_or_and  ", 2, 32'h00000020, 32'h00000001, 0);
        add_word(i_type(32'h123, 0, 0, 1, OP_IMM));
        add_word(i_type(32'h400, 1, 6, 2, OP_IMM));
        add_word(i_type(32'h0f0, 2, 7, 3, OP_IMM));
        add_word(s_type(0, 3, 31));
        add_word(i_type(-1, 1, 3, 4, OP_IMM));
        add_word(s_type(0, 4, 31));
        add_test("reg_add_sub ", 2, 32'h12345064, 32'hedcbb064, 0);
        add_word(i_type(100, 0, 0, 1, OP_IMM));
        add_word(u_type(32'h12345, 2));
        add_word(r_type(0, 2, 1, 0, 3));
        add_word(r_type(32'h20, 2, 1, 0, 4));
        add_word(s_type(0, 3, 31));
        add_word(s_type(0, 4, 31));
        add_test("reg_and_xor ", 2, 32'h000000a5, 32'h0000055a, 0);
        add_word(i_type(32'h5a5, 0, 0, 1, OP_IMM));
        add_word(i_type(32'h0ff, 0, 0, 2, OP_IMM));
        add_word(r_type(0, 2, 1, 7, 3));
        add_word(r_type(0, 2, 1, 4, 4));
        add_word(s_type(0, 3, 31));
        add_word(s_type(0, 4, 31));
        // shift amount 36 uses only its low five bits
        add_test("reg_sll_srl ", 2, 32'hffffff00, 32'h0fffffff, 0);
        add_word(i_type(-16, 0, 0, 1, OP_IMM));
        add_word(i_type(36, 0, 0, 2, OP_IMM));
        add_word(r_type(0, 2, 1, 1, 3));
        add_word(r_type(0, 2, 1, 5, 4));
        add_word(s_type(0, 3, 31));
        add_word(s_type(0, 4, 31));
        // x0 must stay zero, so sltu(x0, 7) is 1 and 56 | 1 is 57
        add_test("reg_sltu_x0 ", 1, 32'd57, 0, 0);
        add_word(i_type(7, 0, 0, 1, OP_IMM));
        add_word(i_type(55, 0, 0, 0, OP_IMM));
        add_word(r_type(0, 1, 0, 3, 2));
        add_word(i_type(3, 1, 1, 3, OP_IMM));
        add_word(r_type(0, 2, 3, 6, 4));
        add_word(s_type(0, 4, 31));
        add_test("load_store  ", 1, 32'hcafe005b, 0, 0);
        add_word(i_type(32'h200, 0, 0, 1, OP_IMM));
        add_word(u_type(32'hcafe0, 2));
        add_word(i_type(32'h05b, 2, 0, 2, OP_IMM));
        add_word(s_type(8, 2, 1));
        add_word(i_type(8, 1, 2, 3, LOAD));
        add_word(s_type(0, 3, 31));
        // branch rows set x1 = 5 and x2 = all ones and each taken branch skips one store
        add_test("branch_beq  ", 1, 32'd5, 0, 0);
        add_word(i_type(5, 0, 0, 1, OP_IMM));
        add_word(i_type(-1, 0, 0, 2, OP_IMM));
        add_word(b_type(8, 2, 1, 0));
        add_word(s_type(0, 1, 31));
        add_word(b_type(8, 1, 1, 0));
        add_word(s_type(0, 2, 31));
        add_test("branch_bne  ", 1, 32'hffffffff, 0, 0);
        add_word(i_type(5, 0, 0, 1, OP_IMM));
        add_word(i_type(-1, 0, 0, 2, OP_IMM));
        add_word(b_type(8, 2, 1, 1));
        add_word(s_type(0, 1, 31));
        add_word(b_type(8, 2, 2, 1));
        add_word(s_type(0, 2, 31));
        add_test("branch_bltu ", 1, 32'hffffffff, 0, 0);
        add_word(i_type(5, 0, 0, 1, OP_IMM));
        add_word(i_type(-1, 0, 0, 2, OP_IMM));
        add_word(b_type(8, 2, 1, 6));
        add_word(s_type(0, 1, 31));
        add_word(b_type(8, 1, 2, 6));
        add_word(s_type(0, 2, 31));
        add_test("branch_bgeu ", 1, 32'd5, 0, 0);
        add_word(i_type(5, 0, 0, 1, OP_IMM));
        add_word(i_type(-1, 0, 0, 2, OP_IMM));
        add_word(b_type(8, 2, 1, 7));
        add_word(s_type(0, 1, 31));
        add_word(b_type(8, 1, 2, 7));
        add_word(s_type(0, 2, 31));
        // link values are the addresses after the JAL at 136 and the JALR at 148
        add_test("jal_jalr    ", 2, 32'd140, 32'd152, 0);
        add_word(j_type(8, 1));
        add_word(s_type(0, 0, 31));
        add_word(s_type(0, 1, 31));
        add_word(i_type(16, 1, 0, 2, JALR));
        add_word(s_type(0, 0, 31));
        add_word(s_type(0, 2, 31));
        add_test("invalid_op  ", 1, 32'd3, 0, 0);
        add_word(i_type(3, 0, 0, 1, OP_IMM));
        add_word(s_type(0, 1, 31));
        add_word(32'h0);
        add_word(s_type(0, 1, 31));
    endtask

    // memory model that reloads the table image while reset is held
    always @(posedge clk) begin
        if (!rst) begin
            mem_ack <= 1'b0;
            waiting <= 1'b0;
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= image_word(cur_test, i);
            end
        end else if (mem_ack) begin
            if (!mem_rd_req && !mem_wr_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_rd_req || mem_wr_req) begin
            if (!waiting) begin
                waiting  <= 1'b1;
                wait_cnt <= $urandom_range(2, 0);
            end else if (wait_cnt == 0) begin
                waiting     <= 1'b0;
                mem_ack     <= 1'b1;
                mem_rd_data <= mem[mem_addr[9:2]];
                if (mem_wr_req) begin
                    mem[mem_addr[9:2]] <= mem_wr_data;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd68d_5ef1));
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            rst       <= 1'b0;
            cur_test  <= t;
            test_name <= names[t];
            exp_vals  <= exp_tab[t];
            exp_n     <= exp_count[t];
            exp_halt  <= halt_tab[t];
            repeat (3) @(posedge clk);
            rst <= 1'b1;
            @(posedge clk);
            while (!halt) begin
                @(posedge clk);
            end
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end
        @(posedge clk);
        $display("tests run: %0d, passed: %0d, failed: %0d", num_tests, pass_count, fail_count);
        if (fail_count == 0 && pass_count == num_tests) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tests/core_checker.sv
// ==========================================================================
// core_checker
// Watches the core's output port, halt and memory handshake, compares
// them with the expected values of each test and prints a result line.
// ==========================================================================
`timescale 1ns/1ps

module core_checker (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::word_t  out,
    input  logic             out_valid,
    input  logic             halt,
    input  logic             mem_rd_req,
    input  logic             mem_wr_req,
    input  logic             mem_ack,
    input  core_pkg::word_t  mem_addr,
    input  logic             test_done,
    input  logic [95:0]      test_name,
    input  logic [2:0][31:0] exp_vals,
    input  int               exp_n,
    input  logic             exp_halt,
    output int               pass_count,
    output int               fail_count
);
    import core_pkg::*;

    word_t got [$];
    logic  req_q      = 1'b0;
    logic  fetch_seen = 1'b0;
    logic  reset_err  = 1'b0;
    logic  fetch_err  = 1'b0;
    logic  hs_err     = 1'b0;
    logic  addr_err   = 1'b0;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // first failure found decides the line for the test
    task automatic report_test();
        string msg;
        msg = "";
        if (reset_err) begin
            msg = $sformatf("%s: halt or out_valid was high during reset", test_name);
        end else if (fetch_err) begin
            msg = $sformatf("%s: first fetch was not from address %0d", test_name, reset_pc);
        end else if (hs_err) begin
            msg = $sformatf("%s: a memory request rose while ack was still high", test_name);
        end else if (addr_err) begin
            msg = $sformatf("%s: a store to the output or halt address reached memory",
                            test_name);
        end else if (got.size() != exp_n) begin
            msg = $sformatf("%s: expected %0d output values but saw %0d",
                            test_name, exp_n, got.size());
        end else begin
            for (int i = 0; i < exp_n; i++) begin
                if (msg == "" && got[i] !== exp_vals[i]) begin
                    msg = $sformatf("Mismatch %s: out[%0d] expected %h actual %h",
                                    test_name, i, exp_vals[i], got[i]);
                end
            end
        end
        if (msg == "" && halt !== exp_halt) begin
            msg = $sformatf("Mismatch %s: halt expected %b actual %b", test_name, exp_halt, halt);
        end
        if (msg == "") begin
            pass_count = pass_count + 1;
            $display("%s: pass", test_name);
        end else begin
            fail_count = fail_count + 1;
            $display("%s", msg);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            req_q = 1'b0;
            if (halt === 1'b1 || out_valid === 1'b1) begin
                reset_err = 1'b1;
            end
        end else begin
            if (out_valid) begin
                got.push_back(out);
            end
            if (mem_rd_req && !fetch_seen) begin
                fetch_seen = 1'b1;
                fetch_err  = mem_addr !== reset_pc;
            end
            // a fresh request needs ack low under the four-phase rule
            if ((mem_rd_req || mem_wr_req) && !req_q && mem_ack) begin
                hs_err = 1'b1;
            end
            // the output and halt addresses are decoded inside the core
            if (mem_wr_req && (mem_addr == out_addr || mem_addr == halt_addr)) begin
                addr_err = 1'b1;
            end
            req_q = mem_rd_req || mem_wr_req;
            if (test_done) begin
                report_test();
                got.delete();
                fetch_seen = 1'b0;
                reset_err  = 1'b0;
                fetch_err  = 1'b0;
                hs_err     = 1'b0;
                addr_err   = 1'b0;
            end
        end
    end

endmodule

//--- design/core_top.sv
// ==========================================================================
// core_top
// Multi-cycle RV32I-subset core. Connects register file, decoder, ALU and
// sequencer, and exposes the req/ack memory port, the output port and halt.
// ==========================================================================
`timescale 1ns/1ps

module core_top (
    input  logic            clk,
    input  logic            rst,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t mem_wr_data,
    output logic            mem_rd_req,
    output logic            mem_wr_req,
    input  core_pkg::word_t mem_rd_data,
    input  logic            mem_ack,
    output core_pkg::word_t out,
    output logic            out_valid,
    output logic            halt
);
    import core_pkg::*;

    decoded_t dec;
    word_t    instr;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     branch_taken;

    rf_if rf_bus ();

    reg_file reg_file_i (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus)
    );

    instr_decode instr_decode_i (
        .instr (instr),
        .dec   (dec)
    );

    alu alu_i (
        .a            (alu_a),
        .b            (alu_b),
        .op           (dec.alu_op),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    core_seq core_seq_i (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .mem_rd_data  (mem_rd_data),
        .mem_ack      (mem_ack),
        .rf           (rf_bus),
        .instr        (instr),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_rd_req   (mem_rd_req),
        .mem_wr_req   (mem_wr_req),
        .out          (out),
        .out_valid    (out_valid),
        .halt         (halt)
    );

endmodule

//--- design/core_seq.sv
// ==========================================================================
// core_seq
// Instruction sequencer: pc and instruction register, four-phase memory
// handshake, writeback selection, output port and halt detection.
// ==========================================================================
`timescale 1ns/1ps

module core_seq (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    alu_result,
    input  logic               branch_taken,
    input  core_pkg::word_t    mem_rd_data,
    input  logic               mem_ack,
    rf_if.sequencer            rf,
    output core_pkg::word_t    instr,
    output core_pkg::word_t    alu_a,
    output core_pkg::word_t    alu_b,
    output core_pkg::word_t    mem_addr,
    output core_pkg::word_t    mem_wr_data,
    output logic               mem_rd_req,
    output logic               mem_wr_req,
    output core_pkg::word_t    out,
    output logic               out_valid,
    output logic               halt
);
    import core_pkg::*;

    core_state_e state;
    word_t       pc;
    word_t       pc_plus4;
    word_t       pc_target;
    word_t       next_pc;
    word_t       wb_data;
    logic        wb_en;
    logic        is_load;
    logic        is_store;
    logic        to_out;
    logic        to_halt;
    logic        fetch_done;

    assign pc_plus4   = pc + 32'd4;
    assign pc_target  = pc + dec.imm;
    assign is_load    = dec.opcode == LOAD;
    assign is_store   = dec.opcode == STORE;
    // alu_result holds rs1+imm for loads and stores
    assign to_out     = is_store && alu_result == out_addr;
    assign to_halt    = is_store && alu_result == halt_addr;
    assign fetch_done = state == fetch && mem_rd_req && mem_ack;

    assign rf.rs1 = dec.rs1;
    assign rf.rs2 = dec.rs2;
    assign rf.rd  = dec.rd;
    assign alu_a  = rf.rs1_data;
    assign alu_b  = dec.use_imm ? dec.imm : rf.rs2_data;

    always_comb begin
        case (dec.opcode)
            BRANCH:  next_pc = branch_taken ? pc_target : pc_plus4;
            JAL:     next_pc = pc_target;
            JALR:    next_pc = {alu_result[xlen-1:1], 1'b0};
            default: next_pc = pc_plus4;
        endcase
    end

    // writeback takes the ALU result, U immediate or link in execute and load data on ack
    always_comb begin
        wb_en   = 1'b0;
        wb_data = alu_result;
        if (state == data_access) begin
            wb_en   = is_load && mem_rd_req && mem_ack;
            wb_data = mem_rd_data;
        end else if (state == execute && dec.valid) begin
            case (dec.opcode)
                OP, OP_IMM: wb_en = 1'b1;
                LUI: begin
                    wb_en   = 1'b1;
                    wb_data = dec.imm;
                end
                JAL, JALR: begin
                    wb_en   = 1'b1;
                    wb_data = pc_plus4;
                end
                default: wb_en = 1'b0;
            endcase
        end
    end

    assign rf.wr_en   = wb_en;
    assign rf.wr_data = wb_data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= fetch;
            pc         <= reset_pc;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_valid  <= 1'b0;
            halt       <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                fetch: begin
                    if (!mem_rd_req) begin
                        mem_rd_req <= 1'b1;
                    end else if (mem_ack) begin
                        mem_rd_req <= 1'b0;
                        state      <= fetch_release;
                    end
                end
                fetch_release: begin
                    if (!mem_ack) begin
                        state <= execute;
                    end
                end
                execute: begin
                    if (!dec.valid || to_halt) begin
                        halt  <= 1'b1;
                        state <= halted;
                    end else if (to_out) begin
                        out_valid <= 1'b1;
                        pc        <= pc_plus4;
                        state     <= fetch;
                    end else if (is_load || is_store) begin
                        // ack is already low here, so the request may rise at once
                        mem_rd_req <= is_load;
                        mem_wr_req <= is_store;
                        state      <= data_access;
                    end else begin
                        pc    <= next_pc;
                        state <= fetch;
                    end
                end
                data_access: begin
                    if (mem_ack) begin
                        mem_rd_req <= 1'b0;
                        mem_wr_req <= 1'b0;
                        state      <= data_release;
                    end
                end
                data_release: begin
                    if (!mem_ack) begin
                        pc    <= pc_plus4;
                        state <= fetch;
                    end
                end
                halted: halt <= 1'b1;
                default: state <= halted;
            endcase
        end
    end

    // address, data and instruction payload
    always_ff @(posedge clk) begin
        if (state == fetch && !mem_rd_req) begin
            mem_addr <= pc;
        end
        if (fetch_done) begin
            instr <= mem_rd_data;
        end
        if (state == execute && (is_load || is_store)) begin
            mem_addr    <= alu_result;
            mem_wr_data <= rf.rs2_data;
        end
        if (state == execute && to_out) begin
            out <= rf.rs2_data;
        end
    end

endmodule

//--- design/alu.sv
// ==========================================================================
// alu
// Add, subtract, logic, logical shifts and unsigned set-less-than, plus
// the four unsigned branch compares. Purely combinational.
// ==========================================================================
`timescale 1ns/1ps

module alu (
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::alu_op_e op,
    output core_pkg::word_t   result,
    output logic              branch_taken
);
    import core_pkg::*;

    logic [4:0] shamt;

    // shift amount only ever uses the low five bits
    assign shamt = b[4:0];

    always_comb begin
        result       = '0;
        branch_taken = 1'b0;
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sltu: result = word_t'(a < b);
            alu_beq:  branch_taken = a == b;
            alu_bne:  branch_taken = a != b;
            alu_bltu: branch_taken = a < b;
            alu_bgeu: branch_taken = a >= b;
            default:  result = '0;
        endcase
    end

endmodule

//--- design/instr_decode.sv
// ==========================================================================
// instr_decode
// Splits the held instruction into register fields, picks the immediate
// for its format and maps funct3/funct7 onto an ALU operation.
// ==========================================================================
`timescale 1ns/1ps

module instr_decode (
    input  core_pkg::word_t    instr,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // all immediates except U are sign-extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec.opcode  = opcode;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.valid   = 1'b1;
        dec.alu_op  = alu_add;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        case (opcode)
            OP: begin
                dec.use_imm = 1'b0;
                case (funct3)
                    3'b000: dec.alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001: dec.alu_op = alu_sll;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b101: dec.alu_op = alu_srl;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    default: dec.valid = 1'b0;
                endcase
                // only SUB may set funct7 bit 5 so SRA is rejected here
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    dec.valid = 1'b0;
                end
            end
            OP_IMM: begin
                case (funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    3'b001: begin
                        dec.alu_op = alu_sll;
                        dec.valid  = funct7 == 7'b0000000;
                    end
                    3'b101: begin
                        dec.alu_op = alu_srl;
                        dec.valid  = funct7 == 7'b0000000;
                    end
                    default: dec.valid = 1'b0;
                endcase
            end
            LOAD: dec.valid = funct3 == 3'b010;
            STORE: begin
                dec.imm   = imm_s;
                dec.valid = funct3 == 3'b010;
            end
            BRANCH: begin
                dec.use_imm = 1'b0;
                dec.imm     = imm_b;
                case (funct3)
                    3'b000: dec.alu_op = alu_beq;
                    3'b001: dec.alu_op = alu_bne;
                    3'b110: dec.alu_op = alu_bltu;
                    3'b111: dec.alu_op = alu_bgeu;
                    default: dec.valid = 1'b0;
                endcase
            end
            JAL: dec.imm = imm_j;
            JALR: dec.valid = funct3 == 3'b000;
            LUI: dec.imm = imm_u;
            default: dec.valid = 1'b0;
        endcase
    end

endmodule

//--- design/reg_file.sv
// ==========================================================================
// reg_file
// 32 x 32-bit integer registers, two combinational reads and one write
// per clock. Writes to x0 are dropped so it always reads zero.
// ==========================================================================
`timescale 1ns/1ps

module reg_file (
    input  logic    clk,
    input  logic    rst,
    rf_if.reg_file  rf
);
    import core_pkg::*;

    word_t regs [num_regs];

    assign rf.rs1_data = regs[rf.rs1];
    assign rf.rs2_data = regs[rf.rs2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.rd != '0) begin
            regs[rf.rd] <= rf.wr_data;
        end
    end

endmodule

//--- common/rf_if.sv
// ==========================================================================
// rf_if
// Register-file access bundle: two read selects with their data and one
// write port, shared between the sequencer and the register array.
// ==========================================================================
`timescale 1ns/1ps

interface rf_if;
    import core_pkg::*;

    reg_sel_t rs1;
    reg_sel_t rs2;
    reg_sel_t rd;
    word_t    wr_data;
    logic     wr_en;
    word_t    rs1_data;
    word_t    rs2_data;

    modport sequencer (
        output rs1, rs2, rd, wr_data, wr_en,
        input  rs1_data, rs2_data
    );

    modport reg_file (
        input  rs1, rs2, rd, wr_data, wr_en,
        output rs1_data, rs2_data
    );

endinterface

//--- common/core_pkg.sv
// ==========================================================================
// core_pkg
// Shared widths, special addresses, state and opcode encodings and the
// decoded-instruction struct used by the multi-cycle RV32I-subset core.
// ==========================================================================

package core_pkg;

    localparam int xlen          = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs      = 32;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;

    localparam word_t reset_pc  = 32'd128;
    // stores to these addresses never reach memory
    localparam word_t out_addr  = 32'd1000000;
    localparam word_t halt_addr = 32'd1000004;

    // major opcodes that the core executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sltu,
        alu_beq,
        alu_bne,
        alu_bltu,
        alu_bgeu
    } alu_op_e;

    typedef enum logic [2:0] {
        fetch,
        fetch_release,
        execute,
        data_access,
        data_release,
        halted
    } core_state_e;

    typedef struct packed {
        opcode_e  opcode;
        logic     valid;
        alu_op_e  alu_op;
        reg_sel_t rd;
        reg_sel_t rs1;
        reg_sel_t rs2;
        logic     use_imm;
        word_t    imm;
    } decoded_t;

endpackage
